// File: hdl/mmu_pkg.sv
//##########################################################
// mmu_pkg: shared Sv32 constants, access and privilege
// encodings, fault causes and the virtual address layout
//##########################################################
package mmu_pkg;

    localparam int XLEN      = 32;
    localparam int PAGE_BITS = 12;
    localparam int VPN_BITS  = 10;
    localparam int PPN_BITS  = 20;

    // kind value is the bit index into {X, W, R}
    typedef enum logic [1:0] {
        ACC_READ  = 2'd0,
        ACC_WRITE = 2'd1,
        ACC_CODE  = 2'd2
    } acc_kind_e;

    localparam logic [1:0] PRIV_U = 2'd0;
    localparam logic [1:0] PRIV_S = 2'd1;
    localparam logic [1:0] PRIV_M = 2'd3;

    // PTE flag positions
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    localparam logic [XLEN-1:0] PTE_A_MASK = 32'h0000_0040;
    localparam logic [XLEN-1:0] PTE_D_MASK = 32'h0000_0080;

    localparam logic [XLEN-1:0] CAUSE_FETCH_PF = 32'd12;
    localparam logic [XLEN-1:0] CAUSE_LOAD_PF  = 32'd13;
    localparam logic [XLEN-1:0] CAUSE_STORE_PF = 32'd15;

    // walker states, also decoded by the memory port mux
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_RD1   = 3'd1;
    localparam logic [2:0] ST_WAIT1 = 3'd2;
    localparam logic [2:0] ST_RD0   = 3'd3;
    localparam logic [2:0] ST_WAIT0 = 3'd4;
    localparam logic [2:0] ST_WB    = 3'd5;
    localparam logic [2:0] ST_RESP  = 3'd6;

    // one virtual address, seen by the walk or by the TLB lookup
    typedef union packed {
        struct packed {
            logic [VPN_BITS-1:0]  vpn1;
            logic [VPN_BITS-1:0]  vpn0;
            logic [PAGE_BITS-1:0] offset;
        } walk;
        struct packed {
            logic [PPN_BITS-1:0]  vpn;
            logic [PAGE_BITS-1:0] offset;
        } look;
    } va_u;

endpackage

// File: hdl/tlb_cache.sv
//##########################################################
// tlb_cache: direct-mapped translation cache, one per
// access kind, cleared by reset or flush
//##########################################################
`timescale 1ns/1ps

module tlb_cache #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                         CLK,
    input  logic                         reset,
    input  logic                         flush,
    input  logic [mmu_pkg::PPN_BITS-1:0] lookup_vpn,
    input  logic                         fill_we,
    input  logic [mmu_pkg::PPN_BITS-1:0] fill_vpn,
    input  logic [mmu_pkg::PPN_BITS-1:0] fill_ppn,
    output logic                         hit,
    output logic [mmu_pkg::PPN_BITS-1:0] ppn
);
    import mmu_pkg::*;

    localparam int IDX_BITS = $clog2(TLB_ENTRIES);
    localparam int TAG_BITS = PPN_BITS - IDX_BITS;

    logic [TLB_ENTRIES-1:0] valid;
    logic [TAG_BITS-1:0]    tag_mem [TLB_ENTRIES];
    logic [PPN_BITS-1:0]    ppn_mem [TLB_ENTRIES];
    logic [IDX_BITS-1:0]    look_idx;
    logic [IDX_BITS-1:0]    fill_idx;
    logic [TAG_BITS-1:0]    look_tag;
    logic [TAG_BITS-1:0]    fill_tag;

    // low page number bits pick the slot, the rest is the tag
    assign {look_tag, look_idx} = lookup_vpn;
    assign {fill_tag, fill_idx} = fill_vpn;

    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            valid <= '0;
        end else if (fill_we) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_we) begin
            tag_mem[fill_idx] <= fill_tag;
            ppn_mem[fill_idx] <= fill_ppn;
        end
    end

    // combinational lookup
    assign hit = valid[look_idx] && (tag_mem[look_idx] == look_tag);
    assign ppn = ppn_mem[look_idx];

endmodule

// File: hdl/pte_check.sv
//##########################################################
// pte_check: decodes one PTE into leaf, pointer or fault
// and builds the A/D update word
//##########################################################
`timescale 1ns/1ps

module pte_check (
    input  logic [mmu_pkg::XLEN-1:0] pte,
    input  logic                     level,
    input  mmu_pkg::acc_kind_e       kind,
    input  logic [1:0]               priv,
    input  logic                     mxr,
    input  logic                     sum,
    output logic                     is_leaf,
    output logic                     is_fault,
    output logic                     needs_update,
    output logic [mmu_pkg::XLEN-1:0] update_word
);
    import mmu_pkg::*;

    localparam int PPN_LSB = 10;

    logic [2:0] xwr;
    logic [2:0] eff_xwr;
    logic       reserved;
    logic       pointer;
    logic       priv_bad;
    logic       perm_bad;
    logic       misaligned;

    assign xwr      = {pte[PTE_X], pte[PTE_W], pte[PTE_R]};
    // MXR makes executable pages readable
    assign eff_xwr  = {xwr[2], xwr[1], xwr[0] | (mxr & xwr[2])};
    assign reserved = pte[PTE_W] & ~pte[PTE_R];
    assign pointer  = (xwr == 3'b000);

    // S mode never fetches from user pages, SUM only opens data access
    assign priv_bad = (priv == PRIV_S && pte[PTE_U] && (!sum || kind == ACC_CODE)) ||
                      (priv == PRIV_U && !pte[PTE_U]);
    assign perm_bad = !eff_xwr[kind];
    // megapage needs its PPN[0] clear
    assign misaligned = level && (pte[PPN_LSB +: VPN_BITS] != '0);

    assign is_leaf  = pte[PTE_V] && !reserved && !pointer;
    assign is_fault = !pte[PTE_V] || reserved || (pointer && !level) ||
                      (is_leaf && (priv_bad || perm_bad || misaligned));

    assign needs_update = !pte[PTE_A] || (kind == ACC_WRITE && !pte[PTE_D]);
    assign update_word  = pte | PTE_A_MASK | ((kind == ACC_WRITE) ? PTE_D_MASK : '0);

endmodule

// File: hdl/page_walker.sv
//##########################################################
// page_walker: request FSM covering bypass, TLB hit, the
// two-level Sv32 walk and the A/D write-back
//##########################################################
`timescale 1ns/1ps

module page_walker (
    input  logic                         CLK,
    input  logic                         reset,
    input  logic                         req_valid,
    input  mmu_pkg::acc_kind_e           req_kind,
    input  logic [mmu_pkg::XLEN-1:0]     vaddr,
    input  logic [1:0]                   priv,
    input  logic [mmu_pkg::XLEN-1:0]     satp,
    input  logic                         mxr,
    input  logic                         sum,
    output logic                         req_ready,
    output logic                         resp_valid,
    output logic [mmu_pkg::XLEN-1:0]     resp_paddr,
    output logic                         resp_fault,
    output logic [mmu_pkg::XLEN-1:0]     resp_cause,
    input  logic                         hit_code,
    input  logic [mmu_pkg::PPN_BITS-1:0] ppn_code,
    input  logic                         hit_load,
    input  logic [mmu_pkg::PPN_BITS-1:0] ppn_load,
    input  logic                         hit_store,
    input  logic [mmu_pkg::PPN_BITS-1:0] ppn_store,
    input  logic                         chk_leaf,
    input  logic                         chk_fault,
    input  logic                         chk_update,
    output mmu_pkg::acc_kind_e           chk_kind,
    output logic [1:0]                   chk_priv,
    output logic                         chk_mxr,
    output logic                         chk_sum,
    output logic [2:0]                   walk_state,
    output logic [mmu_pkg::XLEN-1:0]     pte_q,
    output logic                         walk_level,
    output logic [mmu_pkg::XLEN-1:0]     pte_addr,
    output logic                         fill_we_code,
    output logic                         fill_we_load,
    output logic                         fill_we_store,
    output logic [mmu_pkg::PPN_BITS-1:0] fill_vpn,
    output logic [mmu_pkg::PPN_BITS-1:0] fill_ppn,
    input  logic                         mem_busy,
    input  logic                         mem_rvalid,
    input  logic [mmu_pkg::XLEN-1:0]     mem_rdata
);
    import mmu_pkg::*;

    localparam int PPN_LSB = 10;

    logic [2:0]          state;
    logic                got_pte;
    logic                walked;
    logic                fault_q;
    logic                level_q;
    va_u                 va_in;
    va_u                 va_q;
    acc_kind_e           kind_q;
    logic [1:0]          priv_q;
    logic                mxr_q;
    logic                sum_q;
    logic [XLEN-1:0]     addr_q;
    logic [XLEN-1:0]     paddr_q;
    logic [XLEN-1:0]     leaf_paddr;
    logic                accept;
    logic                bypass;
    logic                hit_sel;
    logic [PPN_BITS-1:0] ppn_sel;
    logic                in_wait;
    logic                decide;

    assign va_in   = vaddr;
    assign accept  = (state == ST_IDLE) && req_valid;
    assign bypass  = (priv == PRIV_M) || !satp[XLEN-1];
    assign in_wait = (state == ST_WAIT1) || (state == ST_WAIT0);
    // verdict is taken one cycle after the PTE lands
    assign decide  = in_wait && got_pte;

    always_comb begin
        case (req_kind)
            ACC_CODE:  {hit_sel, ppn_sel} = {hit_code, ppn_code};
            ACC_WRITE: {hit_sel, ppn_sel} = {hit_store, ppn_store};
            default:   {hit_sel, ppn_sel} = {hit_load, ppn_load};
        endcase
    end

    // megapage keeps vpn0 from the virtual address
    assign leaf_paddr = level_q ?
        {pte_q[PPN_LSB+VPN_BITS +: VPN_BITS], va_q.walk.vpn0, va_q.walk.offset} :
        {pte_q[PPN_LSB +: PPN_BITS], va_q.walk.offset};

    always_ff @(posedge CLK) begin
        if (reset) begin
            state   <= ST_IDLE;
            got_pte <= 1'b0;
            walked  <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        fault_q <= 1'b0;
                        walked  <= !(bypass || hit_sel);
                        state   <= (bypass || hit_sel) ? ST_RESP : ST_RD1;
                    end
                end
                ST_RD1: begin
                    if (!mem_busy)
                        state <= ST_WAIT1;
                end
                ST_RD0: begin
                    if (!mem_busy)
                        state <= ST_WAIT0;
                end
                ST_WAIT1, ST_WAIT0: begin
                    if (mem_rvalid)
                        got_pte <= 1'b1;
                    if (got_pte) begin
                        got_pte <= 1'b0;
                        if (chk_fault) begin
                            fault_q <= 1'b1;
                            state   <= ST_RESP;
                        end else if (chk_leaf) begin
                            state <= chk_update ? ST_WB : ST_RESP;
                        end else begin
                            state <= ST_RD0;
                        end
                    end
                end
                ST_WB: begin
                    if (!mem_busy)
                        state <= ST_RESP;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request copy, PTE and result
    always_ff @(posedge CLK) begin
        if (accept) begin
            va_q    <= va_in;
            kind_q  <= req_kind;
            priv_q  <= priv;
            mxr_q   <= mxr;
            sum_q   <= sum;
            level_q <= 1'b1;
            addr_q  <= {satp[PPN_BITS-1:0], va_in.walk.vpn1, 2'b00};
            paddr_q <= bypass ? vaddr : {ppn_sel, va_in.look.offset};
        end
        if (in_wait && mem_rvalid)
            pte_q <= mem_rdata;
        if (decide) begin
            if (chk_fault) begin
                paddr_q <= '0;
            end else if (chk_leaf) begin
                paddr_q <= leaf_paddr;
            end else begin
                level_q <= 1'b0;
                addr_q  <= {pte_q[PPN_LSB +: PPN_BITS], va_q.walk.vpn0, 2'b00};
            end
        end
    end

    assign req_ready  = (state == ST_IDLE);
    assign resp_valid = (state == ST_RESP);
    assign resp_paddr = paddr_q;
    assign resp_fault = fault_q;

    always_comb begin
        if (!fault_q)
            resp_cause = '0;
        else if (kind_q == ACC_CODE)
            resp_cause = CAUSE_FETCH_PF;
        else if (kind_q == ACC_WRITE)
            resp_cause = CAUSE_STORE_PF;
        else
            resp_cause = CAUSE_LOAD_PF;
    end

    // only a successful walk fills, and only its own kind
    assign fill_we_code  = resp_valid && walked && !fault_q && (kind_q == ACC_CODE);
    assign fill_we_load  = resp_valid && walked && !fault_q && (kind_q == ACC_READ);
    assign fill_we_store = resp_valid && walked && !fault_q && (kind_q == ACC_WRITE);
    assign fill_vpn      = va_q.look.vpn;
    assign fill_ppn      = paddr_q[XLEN-1:PAGE_BITS];

    assign chk_kind   = kind_q;
    assign chk_priv   = priv_q;
    assign chk_mxr    = mxr_q;
    assign chk_sum    = sum_q;
    assign walk_state = state;
    assign walk_level = level_q;
    assign pte_addr   = addr_q;

endmodule

// File: hdl/mem_port_mux.sv
//##########################################################
// mem_port_mux: drives the memory port from the walk state
//##########################################################
`timescale 1ns/1ps

module mem_port_mux (
    input  logic [2:0]               walk_state,
    input  logic [mmu_pkg::XLEN-1:0] pte_addr,
    input  logic [mmu_pkg::XLEN-1:0] update_word,
    input  logic                     mem_busy,
    output logic                     mem_req,
    output logic                     mem_we,
    output logic [mmu_pkg::XLEN-1:0] mem_addr,
    output logic [mmu_pkg::XLEN-1:0] mem_wdata
);
    import mmu_pkg::*;

    logic issue;

    // PTE reads and the write-back are the only bus cycles
    always_comb begin
        case (walk_state)
            ST_RD1, ST_RD0, ST_WB: issue = 1'b1;
            default:               issue = 1'b0;
        endcase
    end

    assign mem_req = issue;
    assign mem_we  = (walk_state == ST_WB);

    // address stays on the bus while memory reports busy
    assign mem_addr = (issue || mem_busy) ? pte_addr : '0;

    // updated PTE comes straight from the checker
    assign mem_wdata = mem_we ? update_word : '0;

endmodule

// File: hdl/mmu_top.sv
//##########################################################
// mmu_top: Sv32 translation unit with split TLBs and a
// single-port page table walker
//##########################################################
`timescale 1ns/1ps

module mmu_top #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                     CLK,
    input  logic                     reset,
    input  logic                     req_valid,
    input  mmu_pkg::acc_kind_e       req_kind,
    input  logic [mmu_pkg::XLEN-1:0] vaddr,
    input  logic [1:0]               priv,
    input  logic [mmu_pkg::XLEN-1:0] satp,
    input  logic                     mxr,
    input  logic                     sum,
    input  logic                     flush,
    output logic                     req_ready,
    output logic                     resp_valid,
    output logic [mmu_pkg::XLEN-1:0] resp_paddr,
    output logic                     resp_fault,
    output logic [mmu_pkg::XLEN-1:0] resp_cause,
    output logic                     mem_req,
    output logic                     mem_we,
    output logic [mmu_pkg::XLEN-1:0] mem_addr,
    output logic [mmu_pkg::XLEN-1:0] mem_wdata,
    input  logic                     mem_busy,
    input  logic [mmu_pkg::XLEN-1:0] mem_rdata,
    input  logic                     mem_rvalid
);
    import mmu_pkg::*;

    logic                hit_code, hit_load, hit_store;
    logic [PPN_BITS-1:0] ppn_code, ppn_load, ppn_store;
    logic                fill_we_code, fill_we_load, fill_we_store;
    logic [PPN_BITS-1:0] fill_vpn, fill_ppn;
    logic                chk_leaf, chk_fault, chk_update;
    acc_kind_e           chk_kind;
    logic [1:0]          chk_priv;
    logic                chk_mxr, chk_sum;
    logic [2:0]          walk_state;
    logic [XLEN-1:0]     pte_q, pte_addr, update_word;
    logic                walk_level;

    page_walker walker (
        .CLK, .reset, .req_valid, .req_kind, .vaddr, .priv, .satp, .mxr, .sum,
        .req_ready, .resp_valid, .resp_paddr, .resp_fault, .resp_cause,
        .hit_code, .ppn_code, .hit_load, .ppn_load, .hit_store, .ppn_store,
        .chk_leaf, .chk_fault, .chk_update, .chk_kind, .chk_priv, .chk_mxr, .chk_sum,
        .walk_state, .pte_q, .walk_level, .pte_addr,
        .fill_we_code, .fill_we_load, .fill_we_store, .fill_vpn, .fill_ppn,
        .mem_busy, .mem_rvalid, .mem_rdata
    );

    pte_check pte_chk (
        .pte(pte_q), .level(walk_level), .kind(chk_kind), .priv(chk_priv),
        .mxr(chk_mxr), .sum(chk_sum), .is_leaf(chk_leaf), .is_fault(chk_fault),
        .needs_update(chk_update), .update_word
    );

    mem_port_mux port_mux (
        .walk_state, .pte_addr, .update_word, .mem_busy,
        .mem_req, .mem_we, .mem_addr, .mem_wdata
    );

    // lookup uses the live request page number
    tlb_cache #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_code (
        .CLK, .reset, .flush, .lookup_vpn(vaddr[XLEN-1:PAGE_BITS]),
        .fill_we(fill_we_code), .fill_vpn, .fill_ppn, .hit(hit_code), .ppn(ppn_code)
    );

    tlb_cache #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_load (
        .CLK, .reset, .flush, .lookup_vpn(vaddr[XLEN-1:PAGE_BITS]),
        .fill_we(fill_we_load), .fill_vpn, .fill_ppn, .hit(hit_load), .ppn(ppn_load)
    );

    tlb_cache #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_store (
        .CLK, .reset, .flush, .lookup_vpn(vaddr[XLEN-1:PAGE_BITS]),
        .fill_we(fill_we_store), .fill_vpn, .fill_ppn, .hit(hit_store), .ppn(ppn_store)
    );

endmodule

// File: tb/mmu_properties.sv
//############################################################
// mmu_properties: handshake assertions bound to mmu_top
//############################################################
`timescale 1ns/1ps

module mmu_properties (
    input logic        CLK,
    input logic        reset,
    input logic        req_valid,
    input logic        req_ready,
    input logic        resp_valid,
    input logic        mem_req,
    input logic        mem_busy,
    input logic        mem_we,
    input logic [31:0] mem_addr
);
    // response is a single cycle pulse
    resp_one_cycle: assert property (@(posedge CLK) disable iff (reset)
        resp_valid |=> !resp_valid)
        else $error("resp_valid held longer than one cycle");

    // no new request while one is in flight
    busy_after_accept: assert property (@(posedge CLK) disable iff (reset)
        (req_valid && req_ready) |=> !req_ready)
        else $error("req_ready high right after acceptance");

    // ready returns only once the response is out
    ready_after_resp: assert property (@(posedge CLK) disable iff (reset)
        $rose(req_ready) |-> $past(resp_valid))
        else $error("req_ready rose without a response");

    stalled_addr: assert property (@(posedge CLK) disable iff (reset)
        (mem_req && mem_busy) |=> mem_req && $stable(mem_addr) && $stable(mem_we))
        else $error("memory request changed while stalled");

endmodule

bind mmu_top mmu_properties props (
    .CLK, .reset, .req_valid, .req_ready, .resp_valid,
    .mem_req, .mem_busy, .mem_we, .mem_addr
);

// File: tb/mmu_checker.sv
//############################################################
// mmu_checker: compares each MMU response with the expected
// row and counts the PTE reads of each request
//############################################################
`timescale 1ns/1ps

module mmu_checker (
    input  logic        CLK,
    input  logic        reset,
    input  logic        req_valid,
    input  logic        req_ready,
    input  logic        resp_valid,
    input  logic [31:0] resp_paddr,
    input  logic        resp_fault,
    input  logic [31:0] resp_cause,
    input  logic        mem_req,
    input  logic        mem_we,
    input  logic        mem_busy,
    input  int          exp_row,
    input  logic [31:0] exp_paddr,
    input  logic        exp_fault,
    input  logic [31:0] exp_cause,
    input  int          exp_reads,
    input  logic [31:0] chk_addr,
    input  logic [31:0] chk_word,
    input  logic [31:0] mem_word,
    output int          pass_count,
    output int          error_count
);
    int reads = 0;
    int latency = 0;
    int row_errs;

    initial begin
        pass_count = 0;
        error_count = 0;
    end

    task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
        $display("[ERROR] %0t: row %0d %s is %h, expected %h", $time, exp_row, what, got, exp);
        row_errs++;
    endtask

    always @(posedge CLK) begin
        if (!reset) begin
            if (req_valid && req_ready) begin
                reads <= 0;
                latency <= 0;
            end else begin
                latency <= latency + 1;
                if (mem_req && !mem_busy && !mem_we)
                    reads <= reads + 1;
            end
            if (resp_valid) begin
                row_errs = 0;
                if (resp_paddr !== exp_paddr)
                    mismatch("paddr", resp_paddr, exp_paddr);
                if (resp_fault !== exp_fault)
                    mismatch("fault", resp_fault, exp_fault);
                if (exp_fault && resp_cause !== exp_cause)
                    mismatch("cause", resp_cause, exp_cause);
                if (reads != exp_reads)
                    mismatch("read count", reads, exp_reads);
                // no walk means the answer comes right after acceptance
                if (exp_reads == 0 && latency != 0)
                    mismatch("latency", latency + 1, 1);
                if (chk_addr != 0 && mem_word !== chk_word)
                    mismatch("PTE in memory", mem_word, chk_word);
                if (row_errs == 0) begin
                    $display("row %0d: pass", exp_row);
                    pass_count <= pass_count + 1;
                end else begin
                    $display("row %0d: fail", exp_row);
                    error_count <= error_count + row_errs;
                end
            end
        end
    end

endmodule

// File: tb/tb_mmu.sv
//############################################################
// tb_mmu: testbench for the Sv32 MMU with a page table memory
// model and a table of requests applied in a loop
//############################################################
`timescale 1ns/1ps

module tb_mmu;
    import mmu_pkg::*;

    localparam int NROWS = 20;
    localparam int CYCLE_LIMIT = 60 * NROWS + 16;
    localparam logic [31:0] SATP_ON = 32'h8000_0002;

    logic CLK = 1'b0;
    logic reset;
    logic req_valid, mxr, sum, flush, req_ready, resp_valid, resp_fault;
    acc_kind_e req_kind;
    logic [1:0] priv;
    logic [31:0] vaddr, satp, resp_paddr, resp_cause;
    logic mem_req, mem_we, mem_busy, mem_rvalid;
    logic [31:0] mem_addr, mem_wdata, mem_rdata;

    // expected values of the row in flight
    int exp_row;
    logic [31:0] exp_paddr, exp_cause, chk_addr, chk_word, mem_word;
    logic exp_fault;
    int exp_reads;
    int pass_count, error_count;

    // stimulus table
    acc_kind_e t_kind [NROWS];
    logic [1:0] t_priv [NROWS];
    logic [31:0] t_satp [NROWS], t_va [NROWS], t_pa [NROWS], t_cause [NROWS];
    logic [31:0] t_caddr [NROWS], t_cword [NROWS];
    logic t_mxr [NROWS], t_sum [NROWS], t_flush [NROWS], t_fault [NROWS];
    int t_reads [NROWS];
    int nrows = 0;

    // page table memory, 16 KiB of words
    logic [31:0] pt_mem [4096];
    logic [31:0] lcg_state = 32'hee19_aaf2;
    logic [31:0] rd_data;
    int rd_wait = 0;
    int cycles = 0;

    always #10 CLK = ~CLK;

    mmu_top UUT (
        .CLK, .reset, .req_valid, .req_kind, .vaddr, .priv, .satp, .mxr, .sum,
        .flush, .req_ready, .resp_valid, .resp_paddr, .resp_fault, .resp_cause,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_busy, .mem_rdata, .mem_rvalid
    );

    assign mem_word = pt_mem[chk_addr[13:2]];

    mmu_checker watch (
        .CLK, .reset, .req_valid, .req_ready, .resp_valid, .resp_paddr,
        .resp_fault, .resp_cause, .mem_req, .mem_we, .mem_busy,
        .exp_row, .exp_paddr, .exp_fault, .exp_cause, .exp_reads,
        .chk_addr, .chk_word, .mem_word, .pass_count, .error_count
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // random busy and a read latency of 1 to 4 cycles
    always @(posedge CLK) begin
        mem_rvalid <= 1'b0;
        lcg_state <= lcg_next(lcg_state);
        mem_busy <= (lcg_state[31:30] == 2'b00);
        if (rd_wait != 0) begin
            rd_wait <= rd_wait - 1;
            if (rd_wait == 1) begin
                mem_rvalid <= 1'b1;
                mem_rdata <= rd_data;
            end
        end
        if (mem_req && !mem_busy) begin
            if (mem_we) begin
                pt_mem[mem_addr[13:2]] <= mem_wdata;
            end else begin
                rd_wait <= int'(lcg_state[21:20]) + 1;
                rd_data <= pt_mem[mem_addr[13:2]];
            end
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the MMU did not answer within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic add_row(input acc_kind_e k, input logic [1:0] p, input logic tr,
                           input logic m, input logic s, input logic f,
                           input logic [31:0] va, input logic [31:0] pa,
                           input logic flt, input int cause, input int reads,
                           input logic [31:0] caddr, input logic [31:0] cword);
        t_kind[nrows] = k;
        t_priv[nrows] = p;
        t_satp[nrows] = tr ? SATP_ON : 32'h0;
        t_mxr[nrows] = m;
        t_sum[nrows] = s;
        t_flush[nrows] = f;
        t_va[nrows] = va;
        t_pa[nrows] = pa;
        t_fault[nrows] = flt;
        t_cause[nrows] = cause;
        t_reads[nrows] = reads;
        t_caddr[nrows] = caddr;
        t_cword[nrows] = cword;
        nrows++;
    endtask

    task automatic apply_row(input int i);
        @(posedge CLK);
        if (t_flush[i]) begin
            flush <= 1'b1;
            @(posedge CLK);
            flush <= 1'b0;
        end
        req_valid <= 1'b1;
        req_kind <= t_kind[i];
        priv <= t_priv[i];
        satp <= t_satp[i];
        mxr <= t_mxr[i];
        sum <= t_sum[i];
        vaddr <= t_va[i];
        exp_row <= i;
        exp_paddr <= t_pa[i];
        exp_fault <= t_fault[i];
        exp_cause <= t_cause[i];
        exp_reads <= t_reads[i];
        chk_addr <= t_caddr[i];
        chk_word <= t_cword[i];
        @(negedge CLK);
        while (!req_ready)
            @(negedge CLK);
        @(posedge CLK);
        req_valid <= 1'b0;
        @(negedge CLK);
        while (!resp_valid)
            @(negedge CLK);
        @(posedge CLK);
    endtask

    initial begin
        reset = 1'b1;
        req_valid = 1'b0;
        req_kind = ACC_READ;
        vaddr = '0;
        priv = PRIV_M;
        satp = '0;
        mxr = 1'b0;
        sum = 1'b0;
        flush = 1'b0;
        mem_busy = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata = '0;
        exp_row = 0;
        exp_paddr = '0;
        exp_fault = 1'b0;
        exp_cause = '0;
        exp_reads = 0;
        chk_addr = '0;
        chk_word = '0;
        for (int a = 0; a < 4096; a++)
            pt_mem[a] = 32'h0;
        // root table at 0x2000, level 0 table at 0x3000
        pt_mem[12'h801] = 32'h2010_00CF;
        pt_mem[12'h802] = 32'h0000_0C01;
        pt_mem[12'hC00] = 32'h048D_1407;
        pt_mem[12'hC01] = 32'h0888_88D7;
        pt_mem[12'hC02] = 32'h0CCC_CC43;
        pt_mem[12'hC04] = 32'h1111_1045;
        pt_mem[12'hC05] = 32'h1555_5449;

        add_row(ACC_READ,  PRIV_M, 1, 0, 0, 0, 32'h1234_5678, 32'h1234_5678, 0, 0, 0, 0, 0);
        add_row(ACC_READ,  PRIV_S, 0, 0, 0, 0, 32'h0040_1234, 32'h0040_1234, 0, 0, 0, 0, 0);
        add_row(ACC_READ,  PRIV_S, 1, 0, 0, 0, 32'h0040_1234, 32'h8040_1234, 0, 0, 1, 0, 0);
        add_row(ACC_READ,  PRIV_S, 1, 0, 0, 0, 32'h0040_1FFC, 32'h8040_1FFC, 0, 0, 0, 0, 0);
        add_row(ACC_CODE,  PRIV_S, 1, 0, 0, 0, 32'h0040_1234, 32'h8040_1234, 0, 0, 1, 0, 0);
        add_row(ACC_READ,  PRIV_S, 1, 0, 0, 0, 32'h0080_0ABC, 32'h1234_5ABC, 0, 0, 2,
                32'h3000, 32'h048D_1447);
        add_row(ACC_WRITE, PRIV_S, 1, 0, 0, 0, 32'h0080_0ABC, 32'h1234_5ABC, 0, 0, 2,
                32'h3000, 32'h048D_14C7);
        add_row(ACC_WRITE, PRIV_S, 1, 0, 0, 0, 32'h0080_0ABC, 32'h1234_5ABC, 0, 0, 0, 0, 0);
        add_row(ACC_READ,  PRIV_S, 1, 0, 0, 0, 32'h0080_1010, 32'h0, 1, 13, 2, 0, 0);
        add_row(ACC_READ,  PRIV_S, 1, 0, 1, 0, 32'h0080_1010, 32'h2222_2010, 0, 0, 2, 0, 0);
        add_row(ACC_WRITE, PRIV_S, 1, 0, 0, 0, 32'h0080_2008, 32'h0, 1, 15, 2, 0, 0);
        add_row(ACC_READ,  PRIV_S, 1, 0, 0, 0, 32'h0080_2008, 32'h3333_3008, 0, 0, 2, 0, 0);
        add_row(ACC_READ,  PRIV_S, 1, 0, 0, 0, 32'h0080_3000, 32'h0, 1, 13, 2, 0, 0);
        add_row(ACC_CODE,  PRIV_S, 1, 0, 0, 0, 32'h0080_4000, 32'h0, 1, 12, 2, 0, 0);
        add_row(ACC_READ,  PRIV_S, 1, 0, 0, 0, 32'h0080_5100, 32'h0, 1, 13, 2, 0, 0);
        add_row(ACC_READ,  PRIV_S, 1, 1, 0, 0, 32'h0080_5100, 32'h5555_5100, 0, 0, 2, 0, 0);
        add_row(ACC_READ,  PRIV_S, 1, 0, 0, 0, 32'h0000_1000, 32'h0, 1, 13, 1, 0, 0);
        add_row(ACC_READ,  PRIV_S, 1, 0, 0, 0, 32'h0080_0ABC, 32'h1234_5ABC, 0, 0, 0, 0, 0);
        add_row(ACC_READ,  PRIV_S, 1, 0, 0, 1, 32'h0080_0ABC, 32'h1234_5ABC, 0, 0, 2, 0, 0);
        add_row(ACC_READ,  PRIV_U, 1, 0, 0, 0, 32'h0080_1010, 32'h2222_2010, 0, 0, 2, 0, 0);

        repeat (16) @(posedge CLK);
        reset <= 1'b0;
        for (int i = 0; i < nrows; i++)
            apply_row(i);
        @(posedge CLK);
        $display("rows passed: %0d of %0d, errors: %0d", pass_count, nrows, error_count);
        if (error_count == 0 && pass_count == nrows) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: flist.f
hdl/mmu_pkg.sv
hdl/tlb_cache.sv
hdl/pte_check.sv
hdl/page_walker.sv
hdl/mem_port_mux.sv
hdl/mmu_top.sv
tb/mmu_properties.sv
tb/mmu_checker.sv
tb/tb_mmu.sv

// File: Makefile
# Verilator build for the Sv32 MMU testbench

VERILATOR ?= verilator
TOP       ?= tb_mmu
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
